// File: xm_reg_interface.f
xm_pkg.sv
mem_req_if.sv
bus_capture.sv
tick_timer.sv
xm_regs.sv
vram_xr_port.sv
xm_reg_interface.sv
tb_mem_model.sv
tb_xm_reg_interface.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_xm_reg_interface
FILELIST   := xm_reg_interface.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
PASS_MSG   := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_xm_reg_interface.sv
// ####################
// directed testbench for the host register block
// drives the host bus and checks registers, VRAM, XR and the timer
// ####################
`timescale 1ns/1ns

module tb_xm_reg_interface import xm_pkg::*; ();

localparam int CLK_PERIOD     = 100;
localparam int RESET_CYCLES   = 8;
localparam int TIMEOUT_CYCLES = 3000;   // tests take about 1500 clocks
localparam int POLL_LIMIT     = 20;
localparam int TIMER_WAIT     = 600;

logic                clk = 1'b0;
logic                reset_i;
logic                bus_cs_n;
logic                bus_rd_nwr;
logic [3:0]          bus_reg_num;
logic                bus_bytesel;
byte_t               bus_data_in;
byte_t               bus_data_out;
logic                vram_sel;
logic                xr_sel;
logic                mem_wr;
logic [WRMASK_W-1:0] mem_wrmask;
addr_t               mem_addr;
word_t               mem_data;
logic                vram_ack;
word_t               vram_rdata;
logic                xr_ack;
word_t               xr_rdata;
logic                load_en;
logic                load_xr;
logic [7:0]          load_addr;
word_t               load_data;
int                  cycle_count = 0;
logic [15:0]         lfsr_state = 16'd9;

always #(CLK_PERIOD/2) clk = ~clk;

xm_reg_interface UUT (
    .clk           (clk),
    .reset_i       (reset_i),
    .bus_cs_n_i    (bus_cs_n),
    .bus_rd_nwr_i  (bus_rd_nwr),
    .bus_reg_num_i (bus_reg_num),
    .bus_bytesel_i (bus_bytesel),
    .bus_data_i    (bus_data_in),
    .bus_data_o    (bus_data_out),
    .vram_sel_o    (vram_sel),
    .xr_sel_o      (xr_sel),
    .mem_wr_o      (mem_wr),
    .mem_wrmask_o  (mem_wrmask),
    .mem_addr_o    (mem_addr),
    .mem_data_o    (mem_data),
    .vram_ack_i    (vram_ack),
    .vram_data_i   (vram_rdata),
    .xr_ack_i      (xr_ack),
    .xr_data_i     (xr_rdata)
);

tb_mem_model u_mem (
    .clk          (clk),
    .reset_i      (reset_i),
    .vram_sel_i   (vram_sel),
    .xr_sel_i     (xr_sel),
    .mem_wr_i     (mem_wr),
    .mem_wrmask_i (mem_wrmask),
    .mem_addr_i   (mem_addr),
    .mem_data_i   (mem_data),
    .load_en_i    (load_en),
    .load_xr_i    (load_xr),
    .load_addr_i  (load_addr),
    .load_data_i  (load_data),
    .vram_ack_o   (vram_ack),
    .vram_data_o  (vram_rdata),
    .xr_ack_o     (xr_ack),
    .xr_data_o    (xr_rdata)
);

task automatic stop_failed(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
endtask

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
        stop_failed($sformatf("timeout, run still going after %0d cycles", TIMEOUT_CYCLES));
    end
end

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic logic [15:0] random_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[14:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
endfunction

task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp)
        else stop_failed($sformatf("ERROR: %s = %h, expected %h", name, got, exp));
endtask

// select low for 4 clocks then high for 4
// read data is taken on the last low clock
task automatic bus_access(input logic rd, input xm_reg_e reg_num, input logic bytesel,
                          input byte_t wdata, output byte_t rdata);
    @(posedge clk);
    bus_cs_n    <= 1'b0;
    bus_rd_nwr  <= rd;
    bus_reg_num <= reg_num;
    bus_bytesel <= bytesel;
    bus_data_in <= wdata;
    repeat (4) @(posedge clk);
    rdata = bus_data_out;
    bus_cs_n <= 1'b1;
    repeat (3) @(posedge clk);
endtask

task automatic bus_write(input xm_reg_e reg_num, input logic bytesel, input byte_t data);
    byte_t ignored;
    bus_access(1'b0, reg_num, bytesel, data, ignored);
endtask

task automatic bus_read(input xm_reg_e reg_num, input logic bytesel, output byte_t data);
    bus_access(1'b1, reg_num, bytesel, 8'h00, data);
endtask

task automatic write_word(input xm_reg_e reg_num, input word_t value);
    bus_write(reg_num, 1'b0, value[15:8]);                  // even byte is high
    bus_write(reg_num, 1'b1, value[7:0]);
endtask

task automatic read_word(input xm_reg_e reg_num, output word_t value);
    byte_t hi;
    byte_t lo;
    bus_read(reg_num, 1'b0, hi);
    bus_read(reg_num, 1'b1, lo);
    value = {hi, lo};
endtask

task automatic wait_mem_idle();
    byte_t status;
    int    polls;
    status = 8'h40;
    polls  = 0;
    while (status[6] && polls < POLL_LIMIT) begin
        bus_read(XM_SYS_CTRL, 1'b1, status);                // bit 6 is mem wait
        polls++;
    end
    if (status[6]) stop_failed("memory wait bit did not clear while polling SYS_CTRL");
endtask

task automatic preload_word(input logic xr, input logic [7:0] addr, input word_t data);
    @(posedge clk);
    load_en   <= 1'b1;
    load_xr   <= xr;
    load_addr <= addr;
    load_data <= data;
    @(posedge clk);
    load_en <= 1'b0;
endtask

task automatic regs_read_back();
    word_t rd_incr_val;
    word_t wr_incr_val;
    word_t xr_addr_val;
    word_t got;
    rd_incr_val = random_bits(16);
    wr_incr_val = random_bits(16);
    xr_addr_val = random_bits(16);
    write_word(XM_RD_INCR, rd_incr_val);
    write_word(XM_WR_INCR, wr_incr_val);
    write_word(XM_XR_ADDR, xr_addr_val);                     // also starts an XR read
    wait_mem_idle();
    read_word(XM_RD_INCR, got);
    check_value("RD_INCR", got, rd_incr_val);
    read_word(XM_WR_INCR, got);
    check_value("WR_INCR", got, wr_incr_val);
    read_word(XM_XR_ADDR, got);
    check_value("XR_ADDR", got, xr_addr_val);
    for (int i = 10; i < 16; i++) begin
        write_word(xm_reg_e'(4'(i)), random_bits(16));      // unused slots drop writes
        read_word(xm_reg_e'(4'(i)), got);
        check_value($sformatf("unused slot %0d", i), got, 16'h0000);
    end
endtask

task automatic vram_write_stride();
    addr_t base;
    addr_t incr;
    addr_t a;
    word_t words [3];
    word_t got;
    base = random_bits(8);
    incr = 16'd1 + random_bits(3);
    write_word(XM_WR_INCR, incr);
    write_word(XM_WR_ADDR, base);
    for (int k = 0; k < 3; k++) begin
        words[k] = random_bits(16);
        write_word(XM_DATA, words[k]);
        wait_mem_idle();
    end
    for (int k = 0; k < 3; k++) begin
        a = base + 16'(k) * incr;
        check_value($sformatf("vram[%h]", a[7:0]), u_mem.vram[a[7:0]], words[k]);
    end
    read_word(XM_WR_ADDR, got);
    check_value("WR_ADDR", got, base + 16'd3 * incr);
endtask

task automatic vram_read_prefetch();
    addr_t base;
    addr_t incr;
    word_t vals [5];
    word_t got;
    base = random_bits(8);
    incr = 16'd1 + random_bits(3);
    for (int k = 0; k < 5; k++) begin
        vals[k] = random_bits(16);
        preload_word(1'b0, 8'(base + 16'(k) * incr), vals[k]);
    end
    write_word(XM_RD_INCR, incr);
    write_word(XM_RD_ADDR, base);                           // first read at base
    wait_mem_idle();
    for (int k = 0; k < 4; k++) begin
        read_word(XM_DATA, got);                            // odd byte starts next prefetch
        check_value($sformatf("DATA read %0d", k), got, vals[k]);
        wait_mem_idle();
    end
    read_word(XM_RD_ADDR, got);
    check_value("RD_ADDR", got, base + 16'd5 * incr);       // five completed reads
endtask

task automatic nibble_mask_write();
    addr_t               a;
    word_t               old_w;
    word_t               new_w;
    word_t               keep;
    word_t               r;
    word_t               got;
    logic [WRMASK_W-1:0] mask;
    a     = random_bits(8);
    old_w = random_bits(16);
    new_w = random_bits(16);
    r     = random_bits(4);
    mask  = (r[3:0] == 4'h0 || r[3:0] == 4'hF) ? 4'h6 : r[3:0];
    keep  = {{4{mask[3]}}, {4{mask[2]}}, {4{mask[1]}}, {4{mask[0]}}};
    preload_word(1'b0, a[7:0], old_w);
    write_word(XM_SYS_CTRL, {12'h000, mask});
    write_word(XM_WR_ADDR, a);
    write_word(XM_DATA, new_w);
    wait_mem_idle();
    check_value("masked vram word", u_mem.vram[a[7:0]], (new_w & keep) | (old_w & ~keep));
    read_word(XM_SYS_CTRL, got);
    check_value("SYS_CTRL", got, {12'h000, mask});
    write_word(XM_SYS_CTRL, 16'h000F);                      // back to full words
endtask

task automatic xr_write_read();
    addr_t a;
    word_t w;
    word_t got;
    a = random_bits(8);
    w = random_bits(16);
    write_word(XM_XR_ADDR, a);
    wait_mem_idle();
    write_word(XM_XR_DATA, w);
    wait_mem_idle();
    check_value($sformatf("xr[%h]", a[7:0]), u_mem.xr[a[7:0]], w);
    read_word(XM_XR_ADDR, got);
    check_value("XR_ADDR", got, a + 16'd1);
    write_word(XM_XR_ADDR, a);                              // reads the word back into XR_DATA
    wait_mem_idle();
    read_word(XM_XR_DATA, got);
    check_value("XR_DATA", got, w);
endtask

task automatic timer_advance();
    word_t t0;
    word_t t1;
    word_t delta;
    int    c0;
    int    c1;
    int    ticks;
    read_word(XM_TIMER, t0);
    c0 = cycle_count;
    repeat (TIMER_WAIT) @(posedge clk);
    read_word(XM_TIMER, t1);
    c1 = cycle_count;
    delta = t1 - t0;
    ticks = (c1 - c0) / TIMER_TICK_CYCLES;
    // the byte reads lie a few clocks apart so the count may be off by one tick
    assert (int'(delta) >= ticks - 1 && int'(delta) <= ticks + 1)
        else stop_failed($sformatf("ERROR: TIMER delta = %h, expected %h within one tick",
                                   delta, ticks));
endtask

initial begin
    reset_i     = 1'b1;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b1;
    bus_reg_num = 4'h0;
    bus_bytesel = 1'b0;
    bus_data_in = 8'h00;
    load_en     = 1'b0;
    load_xr     = 1'b0;
    load_addr   = 8'h00;
    load_data   = 16'h0000;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
    check_value("vram_sel_o", 16'(vram_sel), 16'h0000);
    check_value("xr_sel_o", 16'(xr_sel), 16'h0000);
    check_value("mem_wr_o", 16'(mem_wr), 16'h0000);
    check_value("mem_wrmask_o", 16'(mem_wrmask), 16'h000F);

    regs_read_back();
    vram_write_stride();
    vram_read_prefetch();
    nibble_mask_write();
    xr_write_read();
    timer_advance();

    $display("Test passed");
    $finish;
end

endmodule

// File: tb_mem_model.sv
// ####################
// VRAM and XR model for the testbench
// acks each select after 1 to 4 clocks, preload port fills single words
// ####################
`timescale 1ns/1ns

module tb_mem_model import xm_pkg::*; (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                vram_sel_i,
    input  logic                xr_sel_i,
    input  logic                mem_wr_i,
    input  logic [WRMASK_W-1:0] mem_wrmask_i,
    input  addr_t               mem_addr_i,
    input  word_t               mem_data_i,
    input  logic                load_en_i,      // preload one word
    input  logic                load_xr_i,      // 1 = XR array
    input  logic [7:0]          load_addr_i,
    input  word_t               load_data_i,
    output logic                vram_ack_o,
    output word_t               vram_data_o,
    output logic                xr_ack_o,
    output word_t               xr_data_o
);

word_t       vram [256];
word_t       xr [256];
logic [15:0] lfsr_state = 16'd9;
logic        active;                    // access counting down
logic        acked;                     // ack is out, select drops next edge
logic [2:0]  wait_cnt;
logic [7:0]  idx;

assign idx = mem_addr_i[7:0];           // arrays alias every 256 words

// galois LFSR, one step per bit taken
function automatic logic [15:0] draw_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[14:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return r;
endfunction

function automatic word_t merge_nibbles(input word_t old_w, input word_t new_w,
                                        input logic [WRMASK_W-1:0] mask);
    word_t w;
    w = old_w;
    for (int n = 0; n < WRMASK_W; n++) begin
        if (mask[n]) w[4*n +: 4] = new_w[4*n +: 4];     // bit n enables nibble n
    end
    return w;
endfunction

always @(posedge clk) begin
    if (load_en_i && load_xr_i) xr[load_addr_i] <= load_data_i;
    if (load_en_i && !load_xr_i) vram[load_addr_i] <= load_data_i;
    if (reset_i) begin
        active      <= 1'b0;
        acked       <= 1'b0;
        wait_cnt    <= '0;
        vram_ack_o  <= 1'b0;
        xr_ack_o    <= 1'b0;
        vram_data_o <= '0;
        xr_data_o   <= '0;
    end else begin
        vram_ack_o <= 1'b0;
        xr_ack_o   <= 1'b0;
        acked      <= 1'b0;
        if (!acked) begin
            if (!active) begin
                if (vram_sel_i || xr_sel_i) begin
                    active   <= 1'b1;
                    wait_cnt <= 3'd1 + 3'(draw_bits(2));    // 1 to 4 clocks
                end
            end else if (wait_cnt != 3'd1) begin
                wait_cnt <= wait_cnt - 3'd1;
            end else begin
                active <= 1'b0;
                acked  <= 1'b1;
                if (vram_sel_i) begin
                    vram_ack_o  <= 1'b1;
                    vram_data_o <= vram[idx];
                    if (mem_wr_i) vram[idx] <= merge_nibbles(vram[idx], mem_data_i, mem_wrmask_i);
                end else if (xr_sel_i) begin
                    xr_ack_o  <= 1'b1;
                    xr_data_o <= xr[idx];
                    if (mem_wr_i) xr[idx] <= mem_data_i;    // XR ignores the mask
                end
            end
        end
    end
end

endmodule

// File: xm_reg_interface.sv
// ####################
// top level of the host register block
// host bus in, VRAM and XR select/ack ports out
// ####################
`default_nettype none
`timescale 1ns/1ns

module xm_reg_interface import xm_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    // host bus
    input  wire logic                 bus_cs_n_i,
    input  wire logic                 bus_rd_nwr_i,
    input  wire logic [REG_NUM_W-1:0] bus_reg_num_i,
    input  wire logic                 bus_bytesel_i,
    input  wire byte_t                bus_data_i,
    output      byte_t                bus_data_o,
    // VRAM and XR
    output      logic                 vram_sel_o,
    output      logic                 xr_sel_o,
    output      logic                 mem_wr_o,
    output      logic [WRMASK_W-1:0]  mem_wrmask_o,
    output      addr_t                mem_addr_o,
    output      word_t                mem_data_o,
    input  wire logic                 vram_ack_i,
    input  wire word_t                vram_data_i,
    input  wire logic                 xr_ack_i,
    input  wire word_t                xr_data_i
);

logic                write_strobe;
logic                read_strobe;
xm_reg_e             reg_num;
logic                bytesel;
byte_t               data_byte;
word_t               timer_count;
logic [WRMASK_W-1:0] wrmask;

mem_req_if mem_if();

bus_capture u_bus (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .write_strobe_o (write_strobe),
    .read_strobe_o  (read_strobe),
    .reg_num_o      (reg_num),
    .bytesel_o      (bytesel),
    .data_o         (data_byte)
);

tick_timer u_timer (
    .clk     (clk),
    .reset_i (reset_i),
    .count_o (timer_count)
);

xm_regs u_regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .write_strobe_i (write_strobe),
    .read_strobe_i  (read_strobe),
    .reg_num_i      (reg_num),
    .bytesel_i      (bytesel),
    .data_i         (data_byte),
    .timer_i        (timer_count),
    .bus_data_o     (bus_data_o),
    .wrmask_o       (wrmask),
    .mem            (mem_if)
);

vram_xr_port u_port (
    .clk          (clk),
    .reset_i      (reset_i),
    .vram_ack_i   (vram_ack_i),
    .vram_data_i  (vram_data_i),
    .xr_ack_i     (xr_ack_i),
    .xr_data_i    (xr_data_i),
    .wrmask_i     (wrmask),
    .vram_sel_o   (vram_sel_o),
    .xr_sel_o     (xr_sel_o),
    .mem_wr_o     (mem_wr_o),
    .mem_wrmask_o (mem_wrmask_o),
    .mem_addr_o   (mem_addr_o),
    .mem_data_o   (mem_data_o),
    .mem          (mem_if)
);

endmodule

`default_nettype wire

// File: vram_xr_port.sv
// ####################
// memory side of the register block
// holds VRAM or XR select until its acknowledge and then pulses done
// a new request replaces one still in flight
// ####################
`default_nettype none
`timescale 1ns/1ns

module vram_xr_port import xm_pkg::*; (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                vram_ack_i,
    input  wire word_t               vram_data_i,
    input  wire logic                xr_ack_i,
    input  wire word_t               xr_data_i,
    input  wire logic [WRMASK_W-1:0] wrmask_i,
    output      logic                vram_sel_o,
    output      logic                xr_sel_o,
    output      logic                mem_wr_o,
    output      logic [WRMASK_W-1:0] mem_wrmask_o,
    output      addr_t               mem_addr_o,
    output      word_t               mem_data_o,
    mem_req_if.port                  mem
);

access_op_e cur_op;                     // op of the access in flight
logic       ack_hit;
logic       next_vram;
logic       next_xr;
logic       next_wr;

// acks only count while their own select is up
assign ack_hit  = (vram_sel_o & vram_ack_i) | (xr_sel_o & xr_ack_i);
assign mem.busy = vram_sel_o | xr_sel_o | mem.req_valid;

always_comb begin
    case (mem.op)
        OP_VRAM_RD: {next_vram, next_xr, next_wr} = 3'b100;
        OP_VRAM_WR: {next_vram, next_xr, next_wr} = 3'b101;
        OP_XR_RD:   {next_vram, next_xr, next_wr} = 3'b010;
        OP_XR_WR:   {next_vram, next_xr, next_wr} = 3'b011;
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_sel_o   <= 1'b0;
        xr_sel_o     <= 1'b0;
        mem_wr_o     <= 1'b0;
        mem_wrmask_o <= '1;
        mem.done     <= 1'b0;
    end else begin
        mem.done <= 1'b0;
        if (mem.req_valid) begin
            vram_sel_o   <= next_vram;
            xr_sel_o     <= next_xr;
            mem_wr_o     <= next_wr;
            mem_wrmask_o <= wrmask_i;
        end else if (ack_hit) begin
            vram_sel_o <= 1'b0;
            xr_sel_o   <= 1'b0;
            mem_wr_o   <= 1'b0;
            mem.done   <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (mem.req_valid) begin
        cur_op     <= mem.op;
        mem_addr_o <= mem.addr;
        mem_data_o <= mem.wdata;
    end else if (ack_hit) begin
        mem.done_op <= cur_op;
        mem.rdata   <= vram_sel_o ? vram_data_i : xr_data_i;
    end
end

a_sel_excl: assert property (@(posedge clk) disable iff (reset_i)
    !(vram_sel_o && xr_sel_o));

a_wr_with_sel: assert property (@(posedge clk) disable iff (reset_i)
    $rose(mem_wr_o) |-> ($rose(vram_sel_o) || $rose(xr_sel_o)));

endmodule

`default_nettype wire

// File: xm_regs.sv
// ####################
// host visible register file
// assembles bytes into words, issues VRAM/XR requests and applies completions
// read data for the bus is combinational from the captured register number
// ####################
`default_nettype none
`timescale 1ns/1ns

module xm_regs import xm_pkg::*; (
    input  wire logic          clk,
    input  wire logic          reset_i,
    input  wire logic          write_strobe_i,
    input  wire logic          read_strobe_i,
    input  wire xm_reg_e       reg_num_i,
    input  wire logic          bytesel_i,       // 0 = even (high) byte
    input  wire byte_t         data_i,
    input  wire word_t         timer_i,
    output      byte_t         bus_data_o,
    output      logic [WRMASK_W-1:0] wrmask_o,
    mem_req_if.regs            mem
);

addr_t      reg_xr_addr;
word_t      reg_xr_data;                // XR read buffer
word_t      reg_rd_incr;
addr_t      reg_rd_addr;
word_t      reg_rd_data;                // VRAM read buffer
word_t      reg_wr_incr;
addr_t      reg_wr_addr;
byte_t      xr_data_even;               // high byte waiting for XR_DATA low byte
byte_t      data_even;                  // high byte waiting for DATA low byte

logic       wr_even;
logic       wr_odd;
logic       rd_odd;
logic       is_data;

logic       req_fire;
access_op_e req_op;
addr_t      req_addr;
word_t      req_wdata;
word_t      rd_word;

assign wr_even = write_strobe_i & ~bytesel_i;
assign wr_odd  = write_strobe_i & bytesel_i;
assign rd_odd  = read_strobe_i & bytesel_i;
assign is_data = (reg_num_i == XM_DATA) || (reg_num_i == XM_DATA_2);

// odd byte writes and odd DATA reads start a memory access
always_comb begin
    req_fire  = 1'b0;
    req_op    = OP_VRAM_RD;
    req_addr  = reg_rd_addr;
    req_wdata = {data_even, data_i};
    if (wr_odd) begin
        case (reg_num_i)
            XM_XR_ADDR: begin
                req_fire = 1'b1;
                req_op   = OP_XR_RD;
                req_addr = {reg_xr_addr[15:8], data_i};
            end
            XM_XR_DATA: begin
                req_fire  = 1'b1;
                req_op    = OP_XR_WR;
                req_addr  = reg_xr_addr;
                req_wdata = {xr_data_even, data_i};
            end
            XM_RD_ADDR: begin
                req_fire = 1'b1;
                req_addr = {reg_rd_addr[15:8], data_i};
            end
            XM_DATA, XM_DATA_2: begin
                req_fire = 1'b1;
                req_op   = OP_VRAM_WR;
                req_addr = reg_wr_addr;
            end
            default: ;
        endcase
    end else if (rd_odd && is_data) begin
        req_fire = 1'b1;                // prefetch the next word
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        mem.req_valid <= 1'b0;
    end else begin
        mem.req_valid <= req_fire;
    end
end

always_ff @(posedge clk) begin
    if (req_fire) begin
        mem.op    <= req_op;
        mem.addr  <= req_addr;
        mem.wdata <= req_wdata;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        reg_xr_addr  <= '0;
        reg_xr_data  <= '0;
        reg_rd_incr  <= '0;
        reg_rd_addr  <= '0;
        reg_rd_data  <= '0;
        reg_wr_incr  <= '0;
        reg_wr_addr  <= '0;
        xr_data_even <= '0;
        data_even    <= '0;
        wrmask_o     <= '1;             // all nibbles enabled
    end else begin
        if (mem.done) begin
            case (mem.done_op)
                OP_VRAM_RD: begin
                    reg_rd_data <= mem.rdata;
                    reg_rd_addr <= reg_rd_addr + reg_rd_incr;
                end
                OP_VRAM_WR: reg_wr_addr <= reg_wr_addr + reg_wr_incr;
                OP_XR_RD:   reg_xr_data <= mem.rdata;
                OP_XR_WR:   reg_xr_addr <= reg_xr_addr + 1'b1;
            endcase
        end

        // bus writes come last so they win over a completion
        if (wr_even) begin
            case (reg_num_i)
                XM_XR_ADDR:         reg_xr_addr[15:8] <= data_i;
                XM_XR_DATA:         xr_data_even      <= data_i;
                XM_RD_INCR:         reg_rd_incr[15:8] <= data_i;
                XM_RD_ADDR:         reg_rd_addr[15:8] <= data_i;
                XM_WR_INCR:         reg_wr_incr[15:8] <= data_i;
                XM_WR_ADDR:         reg_wr_addr[15:8] <= data_i;
                XM_DATA, XM_DATA_2: data_even         <= data_i;
                default: ;
            endcase
        end
        if (wr_odd) begin
            case (reg_num_i)
                XM_XR_ADDR:  reg_xr_addr[7:0] <= data_i;
                XM_RD_INCR:  reg_rd_incr[7:0] <= data_i;
                XM_RD_ADDR:  reg_rd_addr[7:0] <= data_i;
                XM_WR_INCR:  reg_wr_incr[7:0] <= data_i;
                XM_WR_ADDR:  reg_wr_addr[7:0] <= data_i;
                XM_SYS_CTRL: wrmask_o         <= data_i[WRMASK_W-1:0];
                default: ;
            endcase
        end
    end
end

always_comb begin
    case (reg_num_i)
        XM_XR_ADDR:         rd_word = reg_xr_addr;
        XM_XR_DATA:         rd_word = reg_xr_data;
        XM_RD_INCR:         rd_word = reg_rd_incr;
        XM_RD_ADDR:         rd_word = reg_rd_addr;
        XM_WR_INCR:         rd_word = reg_wr_incr;
        XM_WR_ADDR:         rd_word = reg_wr_addr;
        XM_DATA, XM_DATA_2: rd_word = reg_rd_data;
        XM_SYS_CTRL:        rd_word = {8'h00, 1'b0, mem.busy, 2'b00, wrmask_o};  // bit 6 = mem wait
        XM_TIMER:           rd_word = timer_i;
        default:            rd_word = '0;
    endcase
    bus_data_o = bytesel_i ? rd_word[7:0] : rd_word[15:8];
end

endmodule

`default_nettype wire

// File: tick_timer.sv
// ####################
// free running timer in tenths of a millisecond
// count wraps past its top value, host reads it through XM_TIMER
// ####################
`default_nettype none
`timescale 1ns/1ns

module tick_timer import xm_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset_i,
    output      word_t count_o
);

logic [TIMER_FRAC_W-1:0] frac;          // clocks within the current tick

always_ff @(posedge clk) begin
    if (reset_i) begin
        frac    <= '0;
        count_o <= '0;
    end else begin
        if (frac == TIMER_FRAC_W'(TIMER_TICK_CYCLES - 1)) begin
            frac    <= '0;
            count_o <= count_o + 1'b1;  // wraps at 16'hFFFF
        end else begin
            frac    <= frac + 1'b1;
        end
    end
end

endmodule

`default_nettype wire

// File: bus_capture.sv
// ####################
// brings the asynchronous host bus into the clock domain
// one read or write strobe per select, fields held until the next select
// ####################
`default_nettype none
`timescale 1ns/1ns

module bus_capture import xm_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 bus_cs_n_i,       // select, active low
    input  wire logic                 bus_rd_nwr_i,     // 1 = read
    input  wire logic [REG_NUM_W-1:0] bus_reg_num_i,
    input  wire logic                 bus_bytesel_i,    // 0 = even (high) byte
    input  wire byte_t                bus_data_i,
    output      logic                 write_strobe_o,
    output      logic                 read_strobe_o,
    output      xm_reg_e              reg_num_o,
    output      logic                 bytesel_o,
    output      byte_t                data_o
);

logic [SYNC_STAGES-1:0] cs_sync;                    // [0] is the first stage
logic [BUS_FIELD_W-1:0] field_sync [SYNC_STAGES];
logic [BUS_FIELD_W-1:0] field_now;
logic                   cs_prev;
logic                   cs_fall;

assign field_now = field_sync[SYNC_STAGES-1];
assign cs_fall   = cs_prev & ~cs_sync[SYNC_STAGES-1];  // select just went low

always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_sync <= '1;                  // idle bus, no false edge
        cs_prev <= 1'b1;
    end else begin
        cs_sync <= {cs_sync[SYNC_STAGES-2:0], bus_cs_n_i};
        cs_prev <= cs_sync[SYNC_STAGES-1];
    end
end

always_ff @(posedge clk) begin
    field_sync[0] <= {bus_rd_nwr_i, bus_reg_num_i, bus_bytesel_i, bus_data_i};
    for (int i = 1; i < SYNC_STAGES; i++) begin
        field_sync[i] <= field_sync[i-1];
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        write_strobe_o <= 1'b0;
        read_strobe_o  <= 1'b0;
        reg_num_o      <= XM_XR_ADDR;
        bytesel_o      <= 1'b0;
    end else begin
        write_strobe_o <= cs_fall & ~field_now[BUS_FIELD_W-1];
        read_strobe_o  <= cs_fall & field_now[BUS_FIELD_W-1];
        if (cs_fall) begin
            reg_num_o <= xm_reg_e'(field_now[BUS_FIELD_W-2 -: REG_NUM_W]);
            bytesel_o <= field_now[$bits(byte_t)];
        end
    end
end

always_ff @(posedge clk) begin
    if (cs_fall) begin
        data_o <= field_now[$bits(byte_t)-1:0];
    end
end

a_strobe_excl: assert property (@(posedge clk) disable iff (reset_i)
    !(write_strobe_o && read_strobe_o));

endmodule

`default_nettype wire

// File: mem_req_if.sv
// ####################
// request and completion channel between the register file and the memory port
// regs side issues requests, port side answers with done
// ####################
`default_nettype none
`timescale 1ns/1ns

interface mem_req_if import xm_pkg::*; ();

    logic       req_valid;              // one cycle request pulse
    access_op_e op;
    addr_t      addr;
    word_t      wdata;

    logic       done;                   // one cycle completion pulse
    access_op_e done_op;                // op that just completed
    word_t      rdata;                  // read data, valid with done
    logic       busy;                   // request pending or in flight

    modport regs (
        output req_valid, op, addr, wdata,
        input  done, done_op, rdata, busy
    );

    modport port (
        input  req_valid, op, addr, wdata,
        output done, done_op, rdata, busy
    );

endinterface

`default_nettype wire

// File: xm_pkg.sv
// ####################
// shared types and constants for the host register block
// import with xm_pkg::* in the module header
// ####################

package xm_pkg;

typedef logic [15:0] word_t;            // register or memory word
typedef logic [15:0] addr_t;            // VRAM or XR address
typedef logic [7:0]  byte_t;            // host bus byte

localparam int REG_NUM_W         = 4;   // register number width on the bus
localparam int WRMASK_W          = 4;   // one enable per nibble
localparam int SYNC_STAGES       = 2;   // flops per synchronized bus input
localparam int TIMER_TICK_CYCLES = 100; // clocks per 1/10 ms, small for sim
localparam int TIMER_FRAC_W      = $clog2(TIMER_TICK_CYCLES);

// rd_nwr, reg_num, bytesel and data travel through the synchronizer as one vector
localparam int BUS_FIELD_W = 1 + REG_NUM_W + 1 + $bits(byte_t);

typedef enum logic [REG_NUM_W-1:0] {
    XM_XR_ADDR   = 4'h0,                // XR address, odd byte write reads XR
    XM_XR_DATA   = 4'h1,                // XR data, odd byte write writes XR
    XM_RD_INCR   = 4'h2,
    XM_RD_ADDR   = 4'h3,                // odd byte write starts VRAM read
    XM_WR_INCR   = 4'h4,
    XM_WR_ADDR   = 4'h5,
    XM_DATA      = 4'h6,                // VRAM data port
    XM_DATA_2    = 4'h7,                // alias of XM_DATA
    XM_SYS_CTRL  = 4'h8,                // mem wait and write mask
    XM_TIMER     = 4'h9,
    XM_UNUSED_A  = 4'hA,
    XM_UNUSED_B  = 4'hB,
    XM_UNUSED_C  = 4'hC,
    XM_UNUSED_D  = 4'hD,
    XM_UNUSED_E  = 4'hE,
    XM_UNUSED_F  = 4'hF
} xm_reg_e;

typedef enum logic [1:0] {
    OP_VRAM_RD = 2'b00,
    OP_VRAM_WR = 2'b01,
    OP_XR_RD   = 2'b10,
    OP_XR_WR   = 2'b11
} access_op_e;

endpackage
